//--- verilog/ex_pkg.sv
//////////////////////////////
// shared widths, word types, unit and function encodings
// issue slot, unit request and unit result structs
//////////////////////////////
`default_nettype none

package ex_pkg;

	parameter int XLEN = 32;
	parameter int TAG_BITS = 6; // tag 0 never writes

	typedef logic [XLEN-1:0] word_t;
	typedef logic [2*XLEN-1:0] dword_t;
	typedef logic [TAG_BITS-1:0] tag_t;

	//////////////////////////////
	// encodings
	//////////////////////////////
	typedef enum logic [1:0] {EX_ALU, EX_MULT, EX_BRANCH} exec_unit_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
	} alu_func_e;

	typedef enum logic [1:0] {MULT_MUL, MULT_MULH, MULT_MULHSU, MULT_MULHU} mult_func_e;

	// same numbering as funct3
	typedef enum logic [2:0] {
		BR_BEQ = 3'b000, BR_BNE = 3'b001, BR_BLT = 3'b100,
		BR_BGE = 3'b101, BR_BLTU = 3'b110, BR_BGEU = 3'b111
	} br_func_e;

	typedef enum logic [1:0] {OPA_RS1, OPA_NPC, OPA_PC, OPA_ZERO} opa_sel_e;
	typedef enum logic {OPB_RS2, OPB_IMM} opb_sel_e;

	//////////////////////////////
	// packets
	//////////////////////////////
	typedef struct packed {
		logic valid;
		exec_unit_e unit;
		alu_func_e alu_func;
		mult_func_e mult_func;
		br_func_e br_func;
		logic cond_branch;
		logic uncond_branch;
		opa_sel_e opa_sel;
		opb_sel_e opb_sel;
		word_t rs1_value;
		word_t rs2_value;
		word_t pc;
		word_t imm; // already sign-extended
		tag_t dest_tag;
	} issue_slot_t;

	typedef struct packed {
		logic valid;
		alu_func_e func;
		word_t opa;
		word_t opb;
		tag_t dest_tag;
	} alu_req_t;

	typedef struct packed {
		logic valid;
		mult_func_e func;
		word_t mcand;
		word_t mplier;
		tag_t dest_tag;
	} mult_req_t;

	typedef struct packed {
		logic valid;
		br_func_e func;
		logic cond_branch;
		logic uncond_branch;
		word_t rs1;
		word_t rs2;
		word_t opa;
		word_t opb;
		tag_t dest_tag;
	} br_req_t;

	typedef struct packed {
		logic valid;
		tag_t dest_tag;
		word_t value;
	} unit_result_t;

endpackage

`default_nettype wire

//--- verilog/mult_stage.sv
//////////////////////////////
// one multiplier pipeline stage
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mult_stage #(
	parameter int MULT_STAGES = 4
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic valid_in,
	input ex_pkg::mult_func_e func_in,
	input ex_pkg::tag_t tag_in,
	input ex_pkg::dword_t mcand_in,
	input ex_pkg::dword_t mplier_in,
	input ex_pkg::dword_t product_in,
	output logic valid_out,
	output ex_pkg::mult_func_e func_out,
	output ex_pkg::tag_t tag_out,
	output ex_pkg::dword_t mcand_out,
	output ex_pkg::dword_t mplier_out,
	output ex_pkg::dword_t product_out
);
	import ex_pkg::*;

	localparam int NUM_BITS = 2*XLEN/MULT_STAGES; // multiplier bits per stage

	dword_t partial;

	assign partial = dword_t'(mplier_in[NUM_BITS-1:0]) * mcand_in;

	always_ff @(posedge clock) begin
		product_out <= product_in + partial;
		mplier_out <= mplier_in >> NUM_BITS;
		mcand_out <= mcand_in << NUM_BITS;
		func_out <= func_in;
		tag_out <= tag_in;
	end

	always_ff @(posedge clock) begin
		if (reset) valid_out <= 1'b0;
		else valid_out <= valid_in;
	end

endmodule

`default_nettype wire

//--- verilog/mult.sv
//////////////////////////////
// pipelined multiplier
// operand sign extension, stage chain, half select
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mult #(
	parameter int MULT_STAGES = 4
) (
	input wire logic clock,
	input wire logic reset,
	input ex_pkg::mult_req_t req,
	output ex_pkg::unit_result_t done
);
	import ex_pkg::*;

	logic signed_a, signed_b;
	logic valid_c [MULT_STAGES+1];
	mult_func_e func_c [MULT_STAGES+1];
	tag_t tag_c [MULT_STAGES+1];
	dword_t mcand_c [MULT_STAGES+1];
	dword_t mplier_c [MULT_STAGES+1];
	dword_t product_c [MULT_STAGES+1];

	// mul/mulh both signed, mulhsu rs1 only, mulhu neither
	assign signed_a = (req.func != MULT_MULHU);
	assign signed_b = (req.func == MULT_MUL) || (req.func == MULT_MULH);

	assign valid_c[0] = req.valid;
	assign func_c[0] = req.func;
	assign tag_c[0] = req.dest_tag;
	assign mcand_c[0] = {{XLEN{signed_a & req.mcand[XLEN-1]}}, req.mcand};
	assign mplier_c[0] = {{XLEN{signed_b & req.mplier[XLEN-1]}}, req.mplier};
	assign product_c[0] = '0;

	for (genvar s = 0; s < MULT_STAGES; s++) begin : g_stage
		mult_stage #(.MULT_STAGES(MULT_STAGES)) u_stage (
			.clock(clock),
			.reset(reset),
			.valid_in(valid_c[s]),
			.func_in(func_c[s]),
			.tag_in(tag_c[s]),
			.mcand_in(mcand_c[s]),
			.mplier_in(mplier_c[s]),
			.product_in(product_c[s]),
			.valid_out(valid_c[s+1]),
			.func_out(func_c[s+1]),
			.tag_out(tag_c[s+1]),
			.mcand_out(mcand_c[s+1]),
			.mplier_out(mplier_c[s+1]),
			.product_out(product_c[s+1])
		);
	end

	assign done.valid = valid_c[MULT_STAGES];
	assign done.dest_tag = tag_c[MULT_STAGES];
	assign done.value = (func_c[MULT_STAGES] == MULT_MUL) ?
		product_c[MULT_STAGES][XLEN-1:0] : product_c[MULT_STAGES][2*XLEN-1:XLEN];

endmodule

`default_nettype wire

//--- verilog/alu.sv
//////////////////////////////
// integer alu, single cycle
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module alu (
	input ex_pkg::alu_req_t req,
	output ex_pkg::word_t result
);
	import ex_pkg::*;

	logic [4:0] shamt;
	logic lt_signed, lt_unsigned;

	assign shamt = req.opb[4:0]; // rv32 shift amount
	assign lt_signed = $signed(req.opa) < $signed(req.opb);
	assign lt_unsigned = req.opa < req.opb;

	always_comb begin
		case (req.func)
			ALU_ADD: result = req.opa + req.opb;
			ALU_SUB: result = req.opa - req.opb;
			ALU_AND: result = req.opa & req.opb;
			ALU_OR: result = req.opa | req.opb;
			ALU_XOR: result = req.opa ^ req.opb;
			ALU_SLT: result = word_t'(lt_signed);
			ALU_SLTU: result = word_t'(lt_unsigned);
			ALU_SLL: result = req.opa << shamt;
			ALU_SRL: result = req.opa >> shamt;
			ALU_SRA: result = word_t'($signed(req.opa) >>> shamt);
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/branch_unit.sv
//////////////////////////////
// branch unit
// condition, take decision, registered target
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
	input wire logic clock,
	input wire logic reset,
	input ex_pkg::br_req_t req,
	output ex_pkg::unit_result_t done,
	output logic taken,
	output ex_pkg::word_t target
);
	import ex_pkg::*;

	logic cond;

	always_comb begin
		case (req.func)
			BR_BEQ: cond = req.rs1 == req.rs2;
			BR_BNE: cond = req.rs1 != req.rs2;
			BR_BLT: cond = $signed(req.rs1) < $signed(req.rs2);
			BR_BGE: cond = $signed(req.rs1) >= $signed(req.rs2);
			BR_BLTU: cond = req.rs1 < req.rs2;
			BR_BGEU: cond = req.rs1 >= req.rs2;
			default: cond = 1'b0;
		endcase
	end

	// writeback entry, value always zero
	assign done = '{valid: req.valid, dest_tag: req.dest_tag, value: '0};

	// held until the next branch
	always_ff @(posedge clock) begin
		if (reset) begin
			taken <= 1'b0;
			target <= '0;
		end else if (req.valid) begin
			taken <= req.uncond_branch | (req.cond_branch & cond);
			target <= req.opa + req.opb;
		end
	end

endmodule

`default_nettype wire

//--- verilog/issue_steer.sv
//////////////////////////////
// issue steering
// first valid slot per unit, operand muxes
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module issue_steer #(
	parameter int N_WAY = 2
) (
	input ex_pkg::issue_slot_t [N_WAY-1:0] issue_slots,
	output ex_pkg::alu_req_t alu_req,
	output ex_pkg::mult_req_t mult_req,
	output ex_pkg::br_req_t br_req
);
	import ex_pkg::*;

	// operand a source
	function automatic word_t opa_of(issue_slot_t s);
		word_t v;
		case (s.opa_sel)
			OPA_RS1: v = s.rs1_value;
			OPA_NPC: v = s.pc + word_t'(4); // npc not carried in the slot
			OPA_PC: v = s.pc;
			default: v = '0;
		endcase
		return v;
	endfunction

	// operand b source
	function automatic word_t opb_of(issue_slot_t s);
		return (s.opb_sel == OPB_IMM) ? s.imm : s.rs2_value;
	endfunction

	always_comb begin
		alu_req = '0;
		mult_req = '0;
		br_req = '0;
		// lower slot wins, later ones for the same unit are ignored
		for (int i = 0; i < N_WAY; i++) begin
			if (issue_slots[i].valid) begin
				if (issue_slots[i].unit == EX_ALU && !alu_req.valid) begin
					alu_req.valid = 1'b1;
					alu_req.func = issue_slots[i].alu_func;
					alu_req.opa = opa_of(issue_slots[i]);
					alu_req.opb = opb_of(issue_slots[i]);
					alu_req.dest_tag = issue_slots[i].dest_tag;
				end
				if (issue_slots[i].unit == EX_MULT && !mult_req.valid) begin
					mult_req.valid = 1'b1;
					mult_req.func = issue_slots[i].mult_func;
					mult_req.mcand = issue_slots[i].rs1_value;
					mult_req.mplier = issue_slots[i].rs2_value;
					mult_req.dest_tag = issue_slots[i].dest_tag;
				end
				if (issue_slots[i].unit == EX_BRANCH && !br_req.valid) begin
					br_req.valid = 1'b1;
					br_req.func = issue_slots[i].br_func;
					br_req.cond_branch = issue_slots[i].cond_branch;
					br_req.uncond_branch = issue_slots[i].uncond_branch;
					br_req.rs1 = issue_slots[i].rs1_value;
					br_req.rs2 = issue_slots[i].rs2_value;
					br_req.opa = opa_of(issue_slots[i]);
					br_req.opb = opb_of(issue_slots[i]);
					br_req.dest_tag = issue_slots[i].dest_tag;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/complete_stage.sv
//////////////////////////////
// completion stage
// packs mult, branch, alu results onto writeback ports
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module complete_stage #(
	parameter int N_WAY = 2
) (
	input wire logic clock,
	input wire logic reset,
	input ex_pkg::unit_result_t mult_done,
	input ex_pkg::unit_result_t br_done,
	input ex_pkg::unit_result_t alu_done,
	input wire logic br_taken_in,
	input ex_pkg::word_t br_target_in,
	output ex_pkg::tag_t [N_WAY-1:0] complete_tag,
	output ex_pkg::word_t [N_WAY-1:0] ex_result,
	output logic [N_WAY-1:0] reg_wr_en,
	output logic take_branch,
	output ex_pkg::word_t br_target
);
	import ex_pkg::*;

	localparam int N_UNITS = 3;
	localparam int BR_IDX = 1; // position of the branch in priority order

	unit_result_t [N_UNITS-1:0] results;
	tag_t [N_WAY-1:0] tag_next;
	word_t [N_WAY-1:0] value_next;
	logic br_wb_next, br_wb_q;

	assign results = {alu_done, br_done, mult_done}; // index 0 first

	//////////////////////////////
	// packing
	//////////////////////////////
	always_comb begin
		int fill;
		fill = 0;
		tag_next = '0;
		value_next = '0;
		br_wb_next = 1'b0;
		for (int r = 0; r < N_UNITS; r++) begin
			if (results[r].valid && fill < N_WAY) begin // overflow dropped
				tag_next[fill] = results[r].dest_tag;
				value_next[fill] = results[r].value;
				if (r == BR_IDX) br_wb_next = 1'b1;
				fill++;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			complete_tag <= '0;
			br_wb_q <= 1'b0;
		end else begin
			complete_tag <= tag_next;
			br_wb_q <= br_wb_next;
		end
	end

	always_ff @(posedge clock) ex_result <= value_next;

	always_comb begin
		for (int w = 0; w < N_WAY; w++) reg_wr_en[w] = (complete_tag[w] != '0); // tag 0 is no dest
	end

	// branch unit registers on the same edge, pulse only with its writeback
	assign take_branch = br_wb_q & br_taken_in;
	assign br_target = br_target_in;

endmodule

`default_nettype wire

//--- verilog/ex_unit.sv
//////////////////////////////
// execute stage top level
// steering, alu, multiplier, branch unit, completion
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ex_unit #(
	parameter int N_WAY = 2,
	parameter int MULT_STAGES = 4
) (
	input wire logic clock,
	input wire logic reset,
	input ex_pkg::issue_slot_t [N_WAY-1:0] issue_slots,
	output ex_pkg::tag_t [N_WAY-1:0] complete_tag,
	output ex_pkg::word_t [N_WAY-1:0] ex_result,
	output logic [N_WAY-1:0] reg_wr_en,
	output logic take_branch,
	output ex_pkg::word_t br_target
);
	import ex_pkg::*;

	alu_req_t alu_req;
	mult_req_t mult_req;
	br_req_t br_req;
	word_t alu_result;
	unit_result_t alu_done, mult_done, br_done;
	logic br_taken;
	word_t br_target_next;

	issue_steer #(.N_WAY(N_WAY)) u_steer (
		.issue_slots(issue_slots),
		.alu_req(alu_req),
		.mult_req(mult_req),
		.br_req(br_req)
	);

	alu u_alu (
		.req(alu_req),
		.result(alu_result)
	);

	// alu is combinational, so the request carries its own tag and valid
	assign alu_done = '{valid: alu_req.valid, dest_tag: alu_req.dest_tag, value: alu_result};

	mult #(.MULT_STAGES(MULT_STAGES)) u_mult (
		.clock(clock),
		.reset(reset),
		.req(mult_req),
		.done(mult_done)
	);

	branch_unit u_branch (
		.clock(clock),
		.reset(reset),
		.req(br_req),
		.done(br_done),
		.taken(br_taken),
		.target(br_target_next)
	);

	complete_stage #(.N_WAY(N_WAY)) u_complete (
		.clock(clock),
		.reset(reset),
		.mult_done(mult_done),
		.br_done(br_done),
		.alu_done(alu_done),
		.br_taken_in(br_taken),
		.br_target_in(br_target_next),
		.complete_tag(complete_tag),
		.ex_result(ex_result),
		.reg_wr_en(reg_wr_en),
		.take_branch(take_branch),
		.br_target(br_target)
	);

endmodule

`default_nettype wire

//--- tests/ex_checker.sv
//////////////////////////////
// writeback checker
// expected completions per cycle, port order, branch outputs
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ex_checker #(
	parameter int N_WAY = 2,
	parameter int MULT_STAGES = 4
) (
	input wire logic clock,
	input wire logic reset,
	input ex_pkg::issue_slot_t [N_WAY-1:0] issue_slots,
	input int exp_test,
	input ex_pkg::word_t [N_WAY-1:0] exp_value,
	input wire logic exp_taken,
	input ex_pkg::word_t exp_target,
	input ex_pkg::tag_t [N_WAY-1:0] complete_tag,
	input ex_pkg::word_t [N_WAY-1:0] ex_result,
	input wire logic [N_WAY-1:0] reg_wr_en,
	input wire logic take_branch,
	input ex_pkg::word_t br_target,
	output int errors,
	output int checks,
	output int pending,
	output int tests_run
);
	import ex_pkg::*;

	localparam int MAX_EXP = 64;
	localparam int MAX_TEST = 64;

	int cyc = 0;
	int n_exp = 0;
	int err_cnt = 0;
	int chk_cnt = 0;
	int pend_cnt = 0;
	int test_cnt = 0;
	logic reset_done = 1'b0;

	// expectation table
	int e_due [MAX_EXP];
	int e_test [MAX_EXP];
	int e_rank [MAX_EXP]; // mult 0, branch 1, alu 2
	tag_t e_tag [MAX_EXP];
	word_t e_value [MAX_EXP];
	logic e_taken [MAX_EXP];
	word_t e_target [MAX_EXP];
	logic e_done [MAX_EXP];
	int test_left [MAX_TEST];
	int test_err [MAX_TEST];

	assign errors = err_cnt;
	assign checks = chk_cnt;
	assign pending = pend_cnt;
	assign tests_run = test_cnt;

	initial begin
		for (int t = 0; t < MAX_TEST; t++) begin
			test_left[t] = 0;
			test_err[t] = 0;
		end
	end

	task automatic compare_value(string name, word_t got, word_t want, int t);
		chk_cnt++;
		if (got !== want) begin
			err_cnt++;
			test_err[t]++;
			$display("ERR %s got %h expected %h (test %0d)", name, got, want, t);
		end
	endtask

	task automatic report_test(int t);
		test_cnt++;
		$display("test %0d: %s, %0d errors", t, (test_err[t] == 0) ? "ok" : "FAILED",
			test_err[t]);
	endtask

	task automatic check_reset_state();
		for (int w = 0; w < N_WAY; w++) begin
			compare_value("complete_tag", word_t'(complete_tag[w]), '0, 0);
			compare_value("reg_wr_en", word_t'(reg_wr_en[w]), '0, 0);
		end
		compare_value("take_branch", word_t'(take_branch), '0, 0);
	endtask

	//////////////////////////////
	// port comparison
	//////////////////////////////
	task automatic compare_ports();
		tag_t want_tag [N_WAY];
		word_t want_val [N_WAY];
		int hit [MAX_EXP];
		int n_hit, fill, cur, t;
		logic br_due, want_taken;
		word_t want_tgt;
		n_hit = 0;
		fill = 0;
		br_due = 1'b0;
		want_taken = 1'b0;
		want_tgt = '0;
		for (int w = 0; w < N_WAY; w++) begin
			want_tag[w] = '0;
			want_val[w] = '0;
		end
		// mult first, then branch, then alu
		for (int rank = 0; rank < 3; rank++) begin
			for (int e = 0; e < n_exp; e++) begin
				if (!e_done[e] && e_due[e] == cyc && e_rank[e] == rank) begin
					if (fill < N_WAY) begin
						want_tag[fill] = e_tag[e];
						want_val[fill] = e_value[e];
						fill++;
					end
					if (rank == 1) begin
						br_due = 1'b1;
						want_taken = e_taken[e];
						want_tgt = e_target[e];
					end
					e_done[e] = 1'b1;
					hit[n_hit] = e;
					n_hit++;
				end
			end
		end
		cur = (n_hit > 0) ? e_test[hit[0]] : 0;
		for (int w = 0; w < N_WAY; w++) begin
			compare_value("complete_tag", word_t'(complete_tag[w]), word_t'(want_tag[w]), cur);
			compare_value("ex_result", ex_result[w], want_val[w], cur);
			compare_value("reg_wr_en", word_t'(reg_wr_en[w]),
				word_t'(want_tag[w] != '0), cur);
		end
		compare_value("take_branch", word_t'(take_branch), word_t'(br_due & want_taken), cur);
		if (br_due) compare_value("br_target", br_target, want_tgt, cur);
		for (int h = 0; h < n_hit; h++) begin
			t = e_test[hit[h]];
			test_left[t]--;
			pend_cnt--;
			if (test_left[t] == 0) report_test(t);
		end
	endtask

	// latency from the unit kind alone
	task automatic record_issue();
		for (int i = 0; i < N_WAY; i++) begin
			if (issue_slots[i].valid && n_exp >= MAX_EXP) begin
				err_cnt++;
				$display("expectation table is full, an issued instruction was not tracked");
			end else if (issue_slots[i].valid) begin
				e_due[n_exp] = cyc + ((issue_slots[i].unit == EX_MULT) ? MULT_STAGES + 1 : 1);
				e_rank[n_exp] = (issue_slots[i].unit == EX_MULT) ? 0 :
					(issue_slots[i].unit == EX_BRANCH) ? 1 : 2;
				e_tag[n_exp] = issue_slots[i].dest_tag;
				e_value[n_exp] = (issue_slots[i].unit == EX_BRANCH) ? '0 : exp_value[i];
				e_taken[n_exp] = exp_taken;
				e_target[n_exp] = exp_target;
				e_test[n_exp] = exp_test;
				e_done[n_exp] = 1'b0;
				test_left[exp_test]++;
				pend_cnt++;
				n_exp++;
			end
		end
	endtask

	always @(posedge clock) begin
		cyc = cyc + 1;
		// outputs hold their power-up value until the first reset edge
		if ((reset || !reset_done) && cyc > 1) check_reset_state();
		if (!reset) begin
			if (!reset_done) begin
				reset_done = 1'b1;
				report_test(0);
			end
			compare_ports();
			record_issue();
		end
	end

endmodule

`default_nettype wire

//--- tests/tb_ex_unit.sv
//////////////////////////////
// ex_unit testbench top
// clock, reset, stimulus file reader, dut and checker
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_ex_unit;
	import ex_pkg::*;

	localparam int N_WAY = 2;
	localparam int MULT_STAGES = 4;
	localparam int DRAIN_LIMIT = 200;

	logic clock, reset;
	issue_slot_t [N_WAY-1:0] issue_slots;
	tag_t [N_WAY-1:0] complete_tag;
	word_t [N_WAY-1:0] ex_result;
	logic [N_WAY-1:0] reg_wr_en;
	logic take_branch;
	word_t br_target;

	// expectations travel next to the slots
	int exp_test;
	word_t [N_WAY-1:0] exp_value;
	logic exp_taken;
	word_t exp_target;
	int errors, checks, pending, tests_run;

	ex_unit #(.N_WAY(N_WAY), .MULT_STAGES(MULT_STAGES)) u_dut (
		.clock(clock), .reset(reset), .issue_slots(issue_slots),
		.complete_tag(complete_tag), .ex_result(ex_result), .reg_wr_en(reg_wr_en),
		.take_branch(take_branch), .br_target(br_target)
	);

	ex_checker #(.N_WAY(N_WAY), .MULT_STAGES(MULT_STAGES)) u_checker (
		.clock(clock), .reset(reset), .issue_slots(issue_slots),
		.exp_test(exp_test), .exp_value(exp_value), .exp_taken(exp_taken),
		.exp_target(exp_target), .complete_tag(complete_tag), .ex_result(ex_result),
		.reg_wr_en(reg_wr_en), .take_branch(take_branch), .br_target(br_target),
		.errors(errors), .checks(checks), .pending(pending), .tests_run(tests_run)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock; // 4 ns period
	end

	task automatic clear_inputs();
		issue_slots = '0;
		exp_value = '0;
		exp_taken = 1'b0;
		exp_target = '0;
		exp_test = 0;
	endtask

	initial begin
		int fd, n, way, drain;
		logic open_fail, timed_out;
		string line;
		logic [31:0] f [18];
		open_fail = 1'b0;
		timed_out = 1'b0;
		clear_inputs();
		reset = 1'b1;
		repeat (8) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		fd = $fopen("tests/ex_stim.txt", "r");
		if (fd == 0) begin
			open_fail = 1'b1;
			$display("could not open the stimulus file tests/ex_stim.txt");
		end else begin
			//////////////////////////////
			// one slot per line, drive on last
			//////////////////////////////
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 0 && line.len() > 0 && line[0] != "#") begin
					n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
						f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
					if (n == 18) begin
						way = f[1];
						exp_test = f[0];
						issue_slots[way].valid = f[3][0];
						issue_slots[way].unit = exec_unit_e'(f[4][1:0]);
						issue_slots[way].alu_func = alu_func_e'(f[5][3:0]);
						issue_slots[way].mult_func = mult_func_e'(f[5][1:0]);
						issue_slots[way].br_func = br_func_e'(f[5][2:0]);
						issue_slots[way].cond_branch = f[6][0];
						issue_slots[way].uncond_branch = f[7][0];
						issue_slots[way].opa_sel = opa_sel_e'(f[8][1:0]);
						issue_slots[way].opb_sel = opb_sel_e'(f[9][0]);
						issue_slots[way].rs1_value = f[10];
						issue_slots[way].rs2_value = f[11];
						issue_slots[way].pc = f[12];
						issue_slots[way].imm = f[13];
						issue_slots[way].dest_tag = f[14][TAG_BITS-1:0];
						exp_value[way] = f[15];
						if (f[4][1:0] == 2'd2) begin
							exp_taken = f[16][0];
							exp_target = f[17];
						end
						if (f[2][0]) begin
							@(negedge clock);
							clear_inputs();
						end
					end
				end
			end
			$fclose(fd);

			drain = 0;
			while (pending > 0 && drain < DRAIN_LIMIT) begin
				@(negedge clock);
				drain++;
			end
			if (pending > 0) begin
				timed_out = 1'b1;
				$display("%0d issued tags never showed up on the writeback ports", pending);
			end
		end

		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0 && !open_fail && !timed_out) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- ex_unit.f
verilog/ex_pkg.sv
verilog/mult_stage.sv
verilog/mult.sv
verilog/alu.sv
verilog/branch_unit.sv
verilog/issue_steer.sv
verilog/complete_stage.sv
verilog/ex_unit.sv
tests/ex_checker.sv
tests/tb_ex_unit.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the ex_unit testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --top-module tb_ex_unit -f ex_unit.f --Mdir obj_dir -o sim_ex_unit
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_ex_unit > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "All checks passed" "$LOG"; then
	exit 0
fi
exit 1

//--- tests/ex_stim.txt
# test way last valid unit func cond uncond opa_sel opb_sel rs1 rs2 pc imm tag
# then expected value, branch taken, branch target; every field in hex
01 0 1 1 0 0 0 0 0 0 1234abcd 0f0f1111 00000000 00000000 01 2143bcde 0 00000000
02 0 1 1 0 1 0 0 0 1 00000010 00000000 00000000 fffffff0 02 00000020 0 00000000
03 0 1 1 0 2 0 0 2 0 00000000 ffff00ff 80001234 00000000 03 80000034 0 00000000
04 0 1 1 0 3 0 0 1 1 00000000 00000000 00000100 00000003 04 00000107 0 00000000
05 0 1 1 0 4 0 0 3 0 00000000 deadbeef 00000000 00000000 05 deadbeef 0 00000000
06 0 1 1 0 5 0 0 0 0 ffffffff 00000001 00000000 00000000 06 00000001 0 00000000
07 0 1 1 0 6 0 0 0 0 ffffffff 00000001 00000000 00000000 07 00000000 0 00000000
08 0 1 1 0 7 0 0 0 1 00000001 00000000 00000000 00000024 08 00000010 0 00000000
09 0 1 1 0 8 0 0 0 0 80000000 0000001f 00000000 00000000 09 00000001 0 00000000
0a 0 1 1 0 9 0 0 0 1 80000000 00000000 00000000 00000004 00 f8000000 0 00000000
0b 0 1 1 1 0 0 0 0 0 80000000 ffffffff 00000000 00000000 0a 80000000 0 00000000
0b 0 1 1 1 1 0 0 0 0 80000000 ffffffff 00000000 00000000 0b 00000000 0 00000000
0b 0 1 1 1 2 0 0 0 0 ffffffff ffffffff 00000000 00000000 0c ffffffff 0 00000000
0b 0 1 1 1 3 0 0 0 0 ffffffff ffffffff 00000000 00000000 0d fffffffe 0 00000000
0c 0 1 1 2 1 1 0 2 1 00000001 00000001 00000400 fffffffc 10 00000000 0 000003fc
0d 0 1 1 2 4 1 0 2 1 fffffff0 00000001 00000800 00000020 11 00000000 1 00000820
0e 0 1 1 2 5 1 0 2 1 fffffff0 00000001 00000800 00000040 12 00000000 0 00000840
0f 0 1 1 2 6 1 0 2 1 fffffff0 00000001 00001000 00000008 13 00000000 0 00001008
10 0 1 1 2 7 1 0 2 1 fffffff0 00000001 00001000 00000010 14 00000000 1 00001010
11 0 1 1 2 0 0 1 0 1 00003000 00000000 00000000 00000100 15 00000000 1 00003100
12 0 0 1 0 0 0 0 0 1 00000005 00000000 00000000 00000007 16 0000000c 0 00000000
12 1 1 1 2 0 1 0 2 1 00000042 00000042 00002000 00000010 17 00000000 1 00002010
13 0 1 1 1 1 0 0 0 0 7fffffff 7fffffff 00000000 00000000 18 3fffffff 0 00000000
13 0 1 0 0 0 0 0 0 0 00000000 00000000 00000000 00000000 00 00000000 0 00000000
13 0 1 0 0 0 0 0 0 0 00000000 00000000 00000000 00000000 00 00000000 0 00000000
13 0 1 0 0 0 0 0 0 0 00000000 00000000 00000000 00000000 00 00000000 0 00000000
13 0 1 1 0 1 0 0 0 0 00000000 00000001 00000000 00000000 19 ffffffff 0 00000000
